/* design/board_ctrl_top.sv */
// top level: request machine, board register file and watchdog timer
`timescale 1ns/1ps

module board_ctrl_top #(
    parameter int          wdog_shift     = 8,        // watchdog prescale bits
    parameter logic [31:0] fw_version     = 32'd9,
    parameter logic [31:0] git_fw_version = 32'd8,
    parameter logic [27:0] git_sha        = 28'h0,
    parameter logic        git_dirty      = 1'b0,
    parameter logic [15:0] git_commits    = 16'd0
) (
    input  logic        sysclk,
    input  logic        rst_n,

    // host request channel
    input  logic        req_valid,
    output logic        req_ready,
    input  logic        req_write,
    input  logic [15:0] req_addr,
    input  logic [31:0] req_wdata,

    // host response channel
    output logic        rsp_valid,
    input  logic        rsp_ready,
    output logic [31:0] rsp_rdata,

    // board control
    input  logic        wdog_clear,
    output logic        reboot,
    output logic        wdog_period_led,
    output logic [2:0]  wdog_period_status,
    output logic        wdog_timeout
);

    // --------------------
    // internal wires
    // --------------------

    logic        wr_main;      // main-space write strobe
    logic        wr_any;       // any write, kicks the watchdog
    logic [3:0]  reg_off;
    logic [31:0] reg_wdata;
    logic [31:0] rd_data;      // read mux output
    logic [15:0] wdog_period;

    reg_req_fsm i_reg_req_fsm (
        .sysclk    (sysclk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req_write (req_write),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp_rdata (rsp_rdata),
        .wr_main   (wr_main),
        .wr_any    (wr_any),
        .reg_off   (reg_off),
        .reg_wdata (reg_wdata),
        .rd_data   (rd_data)
    );

    board_regs #(
        .fw_version     (fw_version),
        .git_fw_version (git_fw_version),
        .git_sha        (git_sha),
        .git_dirty      (git_dirty),
        .git_commits    (git_commits)
    ) i_board_regs (
        .sysclk          (sysclk),
        .rst_n           (rst_n),
        .wr_main         (wr_main),
        .reg_off         (reg_off),
        .reg_wdata       (reg_wdata),
        .rd_data         (rd_data),
        .wdog_period     (wdog_period),
        .reboot          (reboot),
        .wdog_period_led (wdog_period_led)
    );

    // watchdog sees every write, not only main space ones
    wdog_timer #(
        .wdog_shift (wdog_shift)
    ) i_wdog_timer (
        .sysclk             (sysclk),
        .rst_n              (rst_n),
        .wr_any             (wr_any),
        .wdog_clear         (wdog_clear),
        .wdog_period        (wdog_period),
        .wdog_timeout       (wdog_timeout),
        .wdog_period_status (wdog_period_status)
    );

endmodule

/* design/board_pkg.sv */
// address-space code, register offsets, watchdog band codes and limits, reset values
package board_pkg;

    // --------------------
    // address decode
    // --------------------

    // main register space sits in addr[15:12]
    localparam logic [3:0] addr_main = 4'h0;

    // --------------------
    // main space offsets
    // --------------------

    // offsets live in addr[3:0], addr[7:4] must be zero for the main space
    localparam logic [3:0] reg_status   = 4'd0;  // reboot request bits [21:20]
    localparam logic [3:0] reg_phyctrl  = 4'd1;  // phy request word, readback only
    localparam logic [3:0] reg_phydata  = 4'd2;  // phy transfer data, readback only
    localparam logic [3:0] reg_timeout  = 4'd3;  // watchdog period + led mode bit
    localparam logic [3:0] reg_fversion = 4'd4;  // firmware version, read only
    localparam logic [3:0] reg_git_desc = 4'd5;  // git describe word, read only

    // --------------------
    // watchdog bands
    // --------------------

    // band code reported on wdog_period_status
    localparam logic [2:0] wdog_disable     = 3'd0;  // period == 0
    localparam logic [2:0] wdog_phase_one   = 3'd1;  // up to ~50 ms
    localparam logic [2:0] wdog_phase_two   = 3'd2;  // up to ~100 ms
    localparam logic [2:0] wdog_phase_three = 3'd3;  // up to ~150 ms
    localparam logic [2:0] wdog_phase_four  = 3'd4;  // up to ~200 ms
    localparam logic [2:0] wdog_phase_five  = 3'd5;  // anything above

    // inclusive upper limit of each band, in watchdog ticks
    localparam logic [15:0] wdog_lim_one   = 16'h2580;
    localparam logic [15:0] wdog_lim_two   = 16'h4B00;
    localparam logic [15:0] wdog_lim_three = 16'h7080;
    localparam logic [15:0] wdog_lim_four  = 16'h9600;

    // --------------------
    // reset values
    // --------------------

    // 0x1680 ticks, roughly 30 ms at the board clock with an 8 bit prescale
    localparam logic [15:0] wdog_period_rst = 16'h1680;

    // Band limits are inclusive, so a period equal to wdog_lim_one still
    // reports phase one and wdog_lim_one + 1 moves to phase two. The
    // watchdog compares only the upper 16 bits of its counter against
    // the period, which is why the period is a plain 16 bit word here.

endpackage

/* design/board_regs.sv */
// board register file: write decode, read mux, reboot request, version and git describe words
`timescale 1ns/1ps

module board_regs #(
    parameter logic [31:0] fw_version     = 32'd9,   // firmware version
    parameter logic [31:0] git_fw_version = 32'd8,   // last tagged version from git
    parameter logic [27:0] git_sha        = 28'h0,   // abbreviated commit hash
    parameter logic        git_dirty      = 1'b0,    // uncommitted changes at build
    parameter logic [15:0] git_commits    = 16'd0    // commits since the tag
) (
    input  logic        sysclk,
    input  logic        rst_n,

    // write side from the request machine
    input  logic        wr_main,
    input  logic [3:0]  reg_off,
    input  logic [31:0] reg_wdata,

    // read mux, combinational from reg_off
    output logic [31:0] rd_data,

    // control outputs
    output logic [15:0] wdog_period,      // to the watchdog timer
    output logic        reboot,           // fpga reboot request
    output logic        wdog_period_led   // 1 -> led shows the period band
);

    // --------------------
    // storage
    // --------------------

    // phy words are only kept for readback, the transfer happens elsewhere
    logic [15:0] phy_ctrl;   // phy request bitstream
    logic [15:0] phy_data;   // phy register transfer data

    // --------------------
    // git describe word
    // --------------------

    // 33 bit compare so a version of all ones does not wrap
    localparam logic [32:0] fw_ext  = {1'b0, fw_version};
    localparam logic [32:0] git_ext = {1'b0, git_fw_version};

    // version compare code
    //   0: release or post release build (F == G)
    //   1: preview of the next release   (F == G+1)
    //   2: version ran ahead of git      (F >  G+1)
    //   3: version behind git            (F <  G)
    localparam logic [1:0] ver_cmp =
        (fw_ext == git_ext)         ? 2'd0 :
        (fw_ext == git_ext + 33'd1) ? 2'd1 :
        (fw_ext >  git_ext + 33'd1) ? 2'd2 :
                                      2'd3;

    localparam logic commits_nz = (git_commits != 16'd0);  // any commits past the tag

    localparam logic [31:0] git_desc = {git_sha, git_dirty, commits_nz, ver_cmp};

    // --------------------
    // write decode
    // --------------------

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            phy_ctrl        <= 16'd0;
            phy_data        <= 16'd0;
            wdog_period     <= board_pkg::wdog_period_rst;
            wdog_period_led <= 1'b0;
            reboot          <= 1'b0;
        end else if (wr_main) begin
            case (reg_off)
                // bit 21 arms the request, bit 20 carries it
                board_pkg::reg_status:  reboot   <= reg_wdata[21] ? reg_wdata[20] : 1'b0;
                board_pkg::reg_phyctrl: phy_ctrl <= reg_wdata[15:0];
                board_pkg::reg_phydata: phy_data <= reg_wdata[15:0];
                board_pkg::reg_timeout: begin
                    wdog_period_led <= reg_wdata[31];     // led mode
                    wdog_period     <= reg_wdata[15:0];   // 0 disables the watchdog
                end
                default: ;  // read-only or unused offsets ignore writes
            endcase
        end
    end

    // --------------------
    // read mux
    // --------------------

    always_comb begin
        case (reg_off)
            board_pkg::reg_phyctrl:  rd_data = {16'd0, phy_ctrl};
            board_pkg::reg_phydata:  rd_data = {16'd0, phy_data};
            board_pkg::reg_timeout:  rd_data = {wdog_period_led, 15'd0, wdog_period};
            board_pkg::reg_fversion: rd_data = fw_version;
            board_pkg::reg_git_desc: rd_data = git_desc;
            default:                 rd_data = 32'd0;  // status reads back as zero
        endcase
    end

endmodule

/* design/reg_req_fsm.sv */
// request state machine: host handshake, main-space decode, write strobes, read response hold
`timescale 1ns/1ps

module reg_req_fsm (
    input  logic        sysclk,
    input  logic        rst_n,

    // host request channel
    input  logic        req_valid,
    output logic        req_ready,
    input  logic        req_write,   // 1 = write, 0 = read
    input  logic [15:0] req_addr,
    input  logic [31:0] req_wdata,

    // host response channel, reads only
    output logic        rsp_valid,
    input  logic        rsp_ready,
    output logic [31:0] rsp_rdata,

    // register file side
    output logic        wr_main,     // write strobe, main space only
    output logic        wr_any,      // write strobe, any address (watchdog kick)
    output logic [3:0]  reg_off,     // offset for write decode and read mux
    output logic [31:0] reg_wdata,
    input  logic [31:0] rd_data      // combinational read mux from reg_off
);

    // --------------------
    // state and locals
    // --------------------

    typedef enum logic {
        st_idle,   // ready for a request
        st_rsp     // read response pending until the host takes it
    } state_t;

    state_t      state;
    logic        req_acc;    // request transfers this cycle
    logic        req_main;   // request hits the main space
    logic        rd_main;    // latched main-space flag of the read
    logic [31:0] rd_gated;   // mux data or zero outside main space

    assign req_ready = (state == st_idle);  // one request in flight at most
    assign req_acc   = req_valid && req_ready;

    // main space: addr[15:12] matches, addr[7:4] zero
    assign req_main = (req_addr[15:12] == board_pkg::addr_main) && (req_addr[7:4] == 4'd0);

    // --------------------
    // state register
    // --------------------

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (req_acc && !req_write)
                        state <= st_rsp;         // writes stay in idle
                end
                st_rsp: begin
                    if (rsp_ready)
                        state <= st_idle;        // response taken
                end
            endcase
        end
    end

    // one-cycle write strobes, high in the cycle after acceptance
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            wr_any  <= 1'b0;
            wr_main <= 1'b0;
        end else begin
            wr_any  <= req_acc && req_write;
            wr_main <= req_acc && req_write && req_main;
        end
    end

    // --------------------
    // payload registers
    // --------------------

    // offset is taken on reads too, so the mux points at the read target
    // from the acceptance edge on; nothing can write while a read is open
    always_ff @(posedge sysclk) begin
        if (req_acc) begin
            reg_off <= req_addr[3:0];
            rd_main <= req_main;
            if (req_write)
                reg_wdata <= req_wdata;
        end
    end

    assign rd_gated = rd_main ? rd_data : 32'd0;  // outside main space reads zero

    // offset and space flag hold the read target until the response is taken
    assign rsp_valid = (state == st_rsp);
    assign rsp_rdata = rd_gated;

endmodule

/* design/wdog_timer.sv */
// watchdog timer: prescaled counter, sticky timeout flag, period band classification
`timescale 1ns/1ps

module wdog_timer #(
    parameter int wdog_shift = 8   // prescale bits below the compared 16
) (
    input  logic        sysclk,
    input  logic        rst_n,
    input  logic        wr_any,              // any host write restarts the count
    input  logic        wdog_clear,          // clears count and flag (power up)
    input  logic [15:0] wdog_period,         // 0 -> watchdog off
    output logic        wdog_timeout,        // sticky until wdog_clear
    output logic [2:0]  wdog_period_status   // band code of the period
);

    localparam int cnt_w = 16 + wdog_shift;

    logic [cnt_w-1:0] wdog_count;   // upper 16 bits compared against the period

    // --------------------
    // counter and flag
    // --------------------

    // one tick of the period is 2^wdog_shift clocks
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            wdog_count   <= '0;
            wdog_timeout <= 1'b0;
        end else if (wdog_clear) begin
            wdog_count   <= '0;             // restart timer
            wdog_timeout <= 1'b0;           // drop the flag
        end else if (wr_any) begin
            wdog_count <= '0;               // host is alive, flag untouched
        end else if (wdog_period != 16'd0) begin
            if (wdog_count[cnt_w-1:wdog_shift] == wdog_period)
                wdog_timeout <= 1'b1;       // count parks here until cleared
            else
                wdog_count <= wdog_count + cnt_w'(1);
        end
    end

    // --------------------
    // period band
    // --------------------

    function automatic logic [2:0] period_band(input logic [15:0] period);
        if (period == 16'd0)
            return board_pkg::wdog_disable;
        else if (period <= board_pkg::wdog_lim_one)
            return board_pkg::wdog_phase_one;
        else if (period <= board_pkg::wdog_lim_two)
            return board_pkg::wdog_phase_two;
        else if (period <= board_pkg::wdog_lim_three)
            return board_pkg::wdog_phase_three;
        else if (period <= board_pkg::wdog_lim_four)
            return board_pkg::wdog_phase_four;
        else
            return board_pkg::wdog_phase_five;
    endfunction

    // follows the period one cycle later, also while in reset
    always_ff @(posedge sysclk) begin
        wdog_period_status <= period_band(wdog_period);
    end

endmodule

/* filelist.f */
design/board_pkg.sv
design/reg_req_fsm.sv
design/board_regs.sv
design/wdog_timer.sv
design/board_ctrl_top.sv
tests/board_ctrl_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the board control testbench with verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

top=board_ctrl_tb
build_dir=obj_dir
log=sim.log

rm -rf "$build_dir" "$log"

# compile package, rtl and testbench in file list order
verilator --binary --timing --assert \
    --top-module "$top" \
    -f filelist.f \
    --Mdir "$build_dir" \
    -o "sim_$top"

# run and keep the output for the verdict
"./$build_dir/sim_$top" | tee "$log"

if grep -q "TESTBENCH FAILED" "$log"; then
    echo "simulation failed, see $log"
    exit 1
fi

echo "simulation finished without failure"

/* tests/board_ctrl_tb.sv */
// testbench for board_ctrl_top: clock, reset, shadow model, request tasks, assertions, timeout
`timescale 1ns/1ps

module board_ctrl_tb;

    localparam int          tb_shift       = 2;             // short watchdog ticks
    localparam logic [31:0] tb_fw          = 32'h0001_000C;
    localparam logic [31:0] tb_git_fw      = 32'h0001_000B;  // one behind, preview build
    localparam logic [27:0] tb_sha         = 28'hA5C3E19;
    localparam logic        tb_dirty       = 1'b1;
    localparam logic [15:0] tb_commits     = 16'd4;
    localparam int          cycle_limit    = 6000;  // about twice the summed test lengths

    logic        sysclk = 1'b0;
    logic        rst_n;
    logic        req_valid;
    logic        req_ready;
    logic        req_write;
    logic [15:0] req_addr;
    logic [31:0] req_wdata;
    logic        rsp_valid;
    logic        rsp_ready;
    logic [31:0] rsp_rdata;
    logic        wdog_clear;
    logic        reboot;
    logic        wdog_period_led;
    logic [2:0]  wdog_period_status;
    logic        wdog_timeout;

    // shadow of the writable registers
    logic [15:0] sh_phyctrl = 16'd0;
    logic [15:0] sh_phydata = 16'd0;
    logic [15:0] sh_period  = board_pkg::wdog_period_rst;
    logic        sh_led     = 1'b0;
    logic        sh_reboot  = 1'b0;

    int data_errors = 0;
    int hs_errors   = 0;
    int rd_issued   = 0;
    int rsp_seen    = 0;
    int cycle_cnt   = 0;
    int max_stall   = 0;   // longest rsp_ready stall per read

    always #5 sysclk = ~sysclk;

    board_ctrl_top #(
        .wdog_shift     (tb_shift),
        .fw_version     (tb_fw),
        .git_fw_version (tb_git_fw),
        .git_sha        (tb_sha),
        .git_dirty      (tb_dirty),
        .git_commits    (tb_commits)
    ) i_board_ctrl_top (.*);

    // --------------------
    // handshake rules
    // --------------------

    assert property (@(posedge sysclk) disable iff (!rst_n) rsp_valid |-> !req_ready)
        else begin
            hs_errors++;
            $display("error @%0t: req_ready high while a response is pending", $time);
        end

    // stalled response keeps valid and data
    assert property (@(posedge sysclk) disable iff (!rst_n)
                     rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_rdata))
        else begin
            hs_errors++;
            $display("error @%0t: stalled response dropped or changed", $time);
        end

    assert property (@(posedge sysclk) disable iff (!rst_n)
                     wdog_timeout && !wdog_clear |=> wdog_timeout)
        else begin
            hs_errors++;
            $display("error @%0t: timeout flag fell without wdog_clear", $time);
        end

    always @(posedge sysclk) begin
        if (rst_n && rsp_valid && rsp_ready)
            rsp_seen <= rsp_seen + 1;   // one per transferred response
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // --------------------
    // reference model
    // --------------------

    function automatic logic [31:0] git_word();
        logic [32:0] f;
        logic [32:0] g;
        logic [1:0]  cmp;
        f = {1'b0, tb_fw};
        g = {1'b0, tb_git_fw};
        if (f == g)               cmp = 2'd0;
        else if (f == g + 33'd1)  cmp = 2'd1;
        else if (f > g + 33'd1)   cmp = 2'd2;
        else                      cmp = 2'd3;
        return {tb_sha, tb_dirty, tb_commits != 16'd0, cmp};
    endfunction

    function automatic logic [31:0] exp_read(input logic [15:0] addr);
        if (addr[15:12] != board_pkg::addr_main || addr[7:4] != 4'd0)
            return 32'd0;   // outside main space
        case (addr[3:0])
            board_pkg::reg_phyctrl:  return {16'd0, sh_phyctrl};
            board_pkg::reg_phydata:  return {16'd0, sh_phydata};
            board_pkg::reg_timeout:  return {sh_led, 15'd0, sh_period};
            board_pkg::reg_fversion: return tb_fw;
            board_pkg::reg_git_desc: return git_word();
            default:                 return 32'd0;
        endcase
    endfunction

    // band = 1 plus the number of limits the period lies above
    function automatic logic [2:0] exp_band(input logic [15:0] p);
        int n;
        n = 1;
        if (p == 16'd0)
            return board_pkg::wdog_disable;
        if (p > board_pkg::wdog_lim_one)   n++;
        if (p > board_pkg::wdog_lim_two)   n++;
        if (p > board_pkg::wdog_lim_three) n++;
        if (p > board_pkg::wdog_lim_four)  n++;
        return 3'(n);
    endfunction

    task automatic model_write(input logic [15:0] addr, input logic [31:0] data);
        if (addr[15:12] == board_pkg::addr_main && addr[7:4] == 4'd0) begin
            case (addr[3:0])
                board_pkg::reg_status:  sh_reboot  = data[21] & data[20];
                board_pkg::reg_phyctrl: sh_phyctrl = data[15:0];
                board_pkg::reg_phydata: sh_phydata = data[15:0];
                board_pkg::reg_timeout: begin
                    sh_led    = data[31];
                    sh_period = data[15:0];
                end
                default: ;
            endcase
        end
    endtask

    task automatic compare_word(input logic [31:0] got, input logic [31:0] exp,
                                input string what);
        assert (got === exp)
            else begin
                data_errors++;
                $display("error @%0t: %s got 0x%08h expected 0x%08h", $time, what, got, exp);
            end
    endtask

    // --------------------
    // channel tasks
    // --------------------

    // called 1 ns after an edge, returns 1 ns after the transfer edge
    task automatic send_req(input logic wr, input logic [15:0] addr, input logic [31:0] data);
        req_valid = 1'b1;
        req_write = wr;
        req_addr  = addr;
        req_wdata = data;
        while (!req_ready) begin
            @(posedge sysclk);
            #1;
        end
        @(posedge sysclk);   // transfer
        #1;
        req_valid = 1'b0;
    endtask

    task automatic write_reg(input logic [15:0] addr, input logic [31:0] data);
        send_req(1'b1, addr, data);
        model_write(addr, data);
    endtask

    task automatic read_reg(input logic [15:0] addr, output logic [31:0] data);
        int stall;
        send_req(1'b0, addr, 32'd0);
        rd_issued++;
        stall = $urandom_range(max_stall, 0);
        while (!rsp_valid) begin
            @(posedge sysclk);
            #1;
        end
        repeat (stall) begin   // hold the response back
            @(posedge sysclk);
            #1;
        end
        rsp_ready = 1'b1;
        data      = rsp_rdata;
        @(posedge sysclk);
        #1;
        rsp_ready = 1'b0;
    endtask

    task automatic check_read(input logic [15:0] addr);
        logic [31:0] got;
        read_reg(addr, got);
        compare_word(got, exp_read(addr), $sformatf("read of 0x%04h", addr));
    endtask

    task automatic pulse_clear();
        wdog_clear = 1'b1;
        @(posedge sysclk);
        #1;
        wdog_clear = 1'b0;
    endtask

    // --------------------
    // stimulus
    // --------------------

    initial begin
        logic [15:0] addr;
        logic [31:0] data;
        logic [15:0] periods [$];
        int          waited;
        void'($urandom(96));
        rst_n      = 1'b0;
        req_valid  = 1'b0;
        req_write  = 1'b0;
        req_addr   = 16'd0;
        req_wdata  = 32'd0;
        rsp_ready  = 1'b0;
        wdog_clear = 1'b0;
        repeat (4) @(posedge sysclk);
        #1;
        rst_n = 1'b1;

        // reset state
        compare_word({31'd0, rsp_valid}, 32'd0, "rsp_valid after reset");
        compare_word({31'd0, req_ready}, 32'd1, "req_ready after reset");
        compare_word({31'd0, reboot}, 32'd0, "reboot after reset");
        compare_word({31'd0, wdog_timeout}, 32'd0, "timeout after reset");
        compare_word({29'd0, wdog_period_status}, {29'd0, board_pkg::wdog_phase_one},
                     "band after reset");
        read_reg(16'h0003, data);
        compare_word(data, 32'h0000_1680, "timeout register after reset");

        // readback of writable words
        for (int i = 0; i < 24; i++) begin
            addr = {12'h000, 4'($urandom_range(3, 1))};
            write_reg(addr, $urandom);
            check_read(addr);
            compare_word({31'd0, wdog_period_led}, {31'd0, sh_led}, "led mode bit");
        end
        for (int off = 0; off < 16; off++)
            check_read(16'(off));   // id words, status and unused offsets

        // outside main space, writes ignored and reads zero
        for (int i = 0; i < 12; i++) begin
            addr = 16'($urandom);
            if (i % 2 == 0)
                addr[15:12] = 4'h1 + 4'($urandom_range(14, 0));
            else begin
                addr[15:12] = 4'h0;
                addr[7:4]   = 4'h1 + 4'($urandom_range(14, 0));
            end
            addr[3:0]   = 4'((i / 2) % 4);   // status and writable offsets
            data        = $urandom;
            data[21:20] = 2'b11;             // would arm a reboot if taken as status
            write_reg(addr, data);
            check_read(addr);
            check_read(16'h0001);
            check_read(16'h0002);
            check_read(16'h0003);
        end
        compare_word({31'd0, reboot}, {31'd0, sh_reboot}, "reboot after foreign writes");

        // reboot rule, each bit 21/20 pair twice
        for (int c = 0; c < 8; c++) begin
            data     = $urandom;
            data[21] = c[1];
            data[20] = c[0];
            write_reg(16'h0000, data);
            @(posedge sysclk);
            #1;
            compare_word({31'd0, reboot}, {31'd0, sh_reboot}, "reboot request");
        end

        // band limits and their neighbours
        periods = '{16'd0, board_pkg::wdog_lim_one, board_pkg::wdog_lim_one + 16'd1,
                    board_pkg::wdog_lim_two, board_pkg::wdog_lim_two + 16'd1,
                    board_pkg::wdog_lim_three, board_pkg::wdog_lim_three + 16'd1,
                    board_pkg::wdog_lim_four, board_pkg::wdog_lim_four + 16'd1, 16'hFFFF};
        for (int i = 0; i < 8; i++)
            periods.push_back(16'($urandom));
        foreach (periods[i]) begin
            write_reg(16'h0003, {1'b0, 15'd0, periods[i]});
            repeat (2) @(posedge sysclk);   // register, then band register
            #1;
            compare_word({29'd0, wdog_period_status}, {29'd0, exp_band(periods[i])},
                         $sformatf("band of 0x%04h", periods[i]));
        end

        // watchdog kept alive by writes closer than the period
        write_reg(16'h0003, 32'd10);
        pulse_clear();
        for (int i = 0; i < 10; i++) begin
            write_reg(16'h0001, $urandom);
            repeat (25) begin
                @(posedge sysclk);
                #1;
                compare_word({31'd0, wdog_timeout}, 32'd0, "timeout while kicked");
            end
        end
        write_reg(16'h0001, $urandom);   // last kick
        waited = 0;
        while (!wdog_timeout && waited < 60) begin
            @(posedge sysclk);
            #1;
            waited++;
        end
        assert (waited >= 10 * (1 << tb_shift) && waited <= 10 * (1 << tb_shift) + 8)
            else begin
                data_errors++;
                $display("error @%0t: timeout rose after %0d cycles", $time, waited);
            end
        for (int i = 0; i < 3; i++) begin
            write_reg(16'h0002, $urandom);
            compare_word({31'd0, wdog_timeout}, 32'd1, "timeout after writes");
        end
        pulse_clear();
        compare_word({31'd0, wdog_timeout}, 32'd0, "timeout after clear");
        write_reg(16'h0003, 32'd0);      // period zero, watchdog off
        pulse_clear();
        repeat (200) @(posedge sysclk);
        #1;
        compare_word({31'd0, wdog_timeout}, 32'd0, "timeout with period zero");

        // back-pressure on the response channel
        max_stall = 5;
        for (int i = 0; i < 30; i++) begin
            if (i % 4 == 0)
                write_reg({12'h000, 4'($urandom_range(3, 1))}, $urandom);
            check_read({12'h000, 4'($urandom_range(7, 0))});
        end
        compare_word(32'(rsp_seen), 32'(rd_issued), "responses against reads");

        $display("summary: %0d data errors, %0d handshake errors", data_errors, hs_errors);
        if (data_errors + hs_errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule
